// File: hw/valu_pkg.sv
// Fixed 128-bit vector in two 64-bit lanes; elements of 8, 16 or 32 bits, no LMUL grouping
`default_nettype none

package valu_pkg;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////

    localparam int VLEN  = 128;
    localparam int VLENB = VLEN / 8;
    localparam int LANES = 2;
    localparam int LLEN  = VLEN / LANES;
    localparam int LLENB = LLEN / 8;
    // Holds 0 to VLENB
    localparam int VL_W  = 5;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        VNOP,
        VADD, VSUB, VAND, VOR, VXOR,
        VMIN, VMINU, VMAX, VMAXU,
        VMERGE,
        VMSEQ, VMSLT, VMSLTU,
        VREDSUM, VREDAND, VREDOR, VREDXOR, VREDMIN, VREDMAX
    } valu_op_e;

    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vsew_e;

    //////////////////////////////////////////////////////////////////////
    // Request and lane data
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        valu_op_e          op;
        vsew_e             sew;
        logic              vm;    // 1 means unmasked
        logic [VL_W-1:0]   vl;
        logic [VLENB-1:0]  mask;  // Bit i for element i
    } valu_req_t;

    // Same lane word seen at each element width
    typedef union packed {
        logic [7:0][7:0]  b;
        logic [3:0][15:0] h;
        logic [1:0][31:0] w;
    } lane_word_u;

    typedef struct packed {
        lane_word_u        data;
        logic [LLENB-1:0]  cmp;
    } lane_result_t;

endpackage

`default_nettype wire

// File: hw/valu_lane.sv
// Single 64-bit lane; active bits come pre-sliced per element, one register of latency
`timescale 1ns/1ns
`default_nettype none

module valu_lane (
    input  logic                     clk,
    input  logic                     reset_n,
    input  valu_pkg::lane_word_u     first_i,
    input  valu_pkg::lane_word_u     second_i,
    input  valu_pkg::lane_word_u     third_i,
    input  valu_pkg::valu_op_e       op_i,
    input  valu_pkg::vsew_e          sew_i,
    input  logic [valu_pkg::LLENB-1:0] active_i,
    output valu_pkg::lane_result_t   result_o
);

    valu_pkg::lane_result_t lane_next;

    // Operands arrive left-justified in 32 bits, so one set of
    // signed and unsigned compares and a 32-bit adder serve every width.
    // Returns {compare bit, data}
    function automatic logic [32:0] elem_calc(
        input valu_pkg::valu_op_e op,
        input logic [31:0]        a,
        input logic [31:0]        b,
        input logic [31:0]        c
    );
        logic lt_s;
        logic lt_u;
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        case (op)
            valu_pkg::VADD:   return {1'b0, a + b};
            valu_pkg::VSUB:   return {1'b0, a - b};
            valu_pkg::VAND:   return {1'b0, a & b};
            valu_pkg::VOR:    return {1'b0, a | b};
            valu_pkg::VXOR:   return {1'b0, a ^ b};
            valu_pkg::VMIN:   return {1'b0, lt_s ? a : b};
            valu_pkg::VMINU:  return {1'b0, lt_u ? a : b};
            valu_pkg::VMAX:   return {1'b0, lt_s ? b : a};
            valu_pkg::VMAXU:  return {1'b0, lt_u ? b : a};
            valu_pkg::VMERGE: return {1'b0, b};
            // Compares leave the destination untouched
            valu_pkg::VMSEQ:  return {a == b, c};
            valu_pkg::VMSLT:  return {lt_s, c};
            valu_pkg::VMSLTU: return {lt_u, c};
            default:          return {1'b0, c};
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Element datapath
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic [32:0] res;
        lane_next.data = third_i;
        lane_next.cmp  = '0;
        case (sew_i)
            valu_pkg::EW8: begin
                for (int e = 0; e < 8; e++) begin
                    res = elem_calc(op_i, {first_i.b[e], 24'b0},
                                    {second_i.b[e], 24'b0}, {third_i.b[e], 24'b0});
                    if (active_i[e]) begin
                        lane_next.data.b[e] = res[31:24];
                        lane_next.cmp[e]    = res[32];
                    end
                end
            end
            valu_pkg::EW16: begin
                for (int e = 0; e < 4; e++) begin
                    res = elem_calc(op_i, {first_i.h[e], 16'b0},
                                    {second_i.h[e], 16'b0}, {third_i.h[e], 16'b0});
                    if (active_i[e]) begin
                        lane_next.data.h[e] = res[31:16];
                        lane_next.cmp[e]    = res[32];
                    end
                end
            end
            default: begin
                for (int e = 0; e < 2; e++) begin
                    res = elem_calc(op_i, first_i.w[e], second_i.w[e], third_i.w[e]);
                    if (active_i[e]) begin
                        lane_next.data.w[e] = res[31:0];
                        lane_next.cmp[e]    = res[32];
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            result_o <= '0;
        end else begin
            result_o <= lane_next;
        end
    end

endmodule

`default_nettype wire

// File: hw/valu_reduction.sv
// Signed min and max only; seed is element 0 of the scalar operand, zero-extended to 32 bits
`timescale 1ns/1ns
`default_nettype none

module valu_reduction (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start_i,
    input  valu_pkg::valu_op_e         op_i,
    input  valu_pkg::vsew_e            sew_i,
    input  logic [valu_pkg::VLEN-1:0]  vector_i,
    input  logic [31:0]                seed_i,
    input  logic [valu_pkg::VLENB-1:0] active_i,
    output logic [31:0]                result_o
);

    logic [valu_pkg::LANES-1:0][31:0] partial_next;
    logic [valu_pkg::LANES-1:0][31:0] partial_q;
    logic [31:0]                      seed_q;
    valu_pkg::valu_op_e               op_q;
    valu_pkg::vsew_e                  sew_q;
    logic                             stage1_valid;
    logic [4:0]                       shift_q;
    logic [31:0]                      total;

    // All values are left-justified, so low bits stay zero and wrap is free
    function automatic logic [31:0] red_combine(
        input valu_pkg::valu_op_e op,
        input logic [31:0]        a,
        input logic [31:0]        b
    );
        case (op)
            valu_pkg::VREDSUM: return a + b;
            valu_pkg::VREDAND: return a & b;
            valu_pkg::VREDOR:  return a | b;
            valu_pkg::VREDXOR: return a ^ b;
            valu_pkg::VREDMIN: return ($signed(a) < $signed(b)) ? a : b;
            valu_pkg::VREDMAX: return ($signed(a) < $signed(b)) ? b : a;
            default:           return a;
        endcase
    endfunction

    // Stage 1: fold each lane, inactive elements contribute the identity
    always_comb begin
        valu_pkg::lane_word_u word;
        logic [31:0]          elem;
        logic                 elem_active;
        for (int k = 0; k < valu_pkg::LANES; k++) begin
            word = vector_i[k*valu_pkg::LLEN +: valu_pkg::LLEN];
            case (op_i)
                valu_pkg::VREDAND: partial_next[k] = '1;
                valu_pkg::VREDMIN: partial_next[k] = 32'h7FFF_FFFF;
                valu_pkg::VREDMAX: partial_next[k] = 32'h8000_0000;
                default:           partial_next[k] = '0;
            endcase
            for (int e = 0; e < valu_pkg::LLENB; e++) begin
                case (sew_i)
                    valu_pkg::EW8: begin
                        elem        = {word.b[e], 24'b0};
                        elem_active = active_i[k*8 + e];
                    end
                    valu_pkg::EW16: begin
                        elem        = {word.h[e%4], 16'b0};
                        elem_active = (e < 4) && active_i[k*4 + e];
                    end
                    default: begin
                        elem        = word.w[e%2];
                        elem_active = (e < 2) && active_i[k*2 + e];
                    end
                endcase
                if (elem_active) begin
                    partial_next[k] = red_combine(op_i, partial_next[k], elem);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage1_valid <= 1'b0;
        end else begin
            stage1_valid <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            partial_q <= partial_next;
            seed_q    <= seed_i;
            op_q      <= op_i;
            sew_q     <= sew_i;
        end
    end

    // Stage 2: seed joins both partials, then back to element width
    always_comb begin
        case (sew_q)
            valu_pkg::EW8:  shift_q = 5'd24;
            valu_pkg::EW16: shift_q = 5'd16;
            default:        shift_q = 5'd0;
        endcase
        total = red_combine(op_q, seed_q << shift_q, partial_q[0]);
        total = red_combine(op_q, total, partial_q[1]);
    end

    always_ff @(posedge clk) begin
        if (stage1_valid) begin
            result_o <= total >> shift_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/vector_alu.sv
// No back-pressure; every request returns 2 cycles later, result_o only valid with result_valid_o
`timescale 1ns/1ns
`default_nettype none

module vector_alu (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       req_valid_i,
    input  valu_pkg::valu_req_t        req_i,
    input  logic [valu_pkg::VLEN-1:0]  first_operand_i,
    input  logic [valu_pkg::VLEN-1:0]  second_operand_i,
    input  logic [valu_pkg::VLEN-1:0]  third_operand_i,
    output logic                       result_valid_o,
    output logic [valu_pkg::VLEN-1:0]  result_o,
    output logic [valu_pkg::VLENB-1:0] result_mask_o
);

    logic [valu_pkg::VLENB-1:0]                  in_vl;
    logic [valu_pkg::VLENB-1:0]                  active;
    logic [valu_pkg::LANES-1:0][valu_pkg::LLENB-1:0] lane_active;
    logic [valu_pkg::VLEN-1:0]                   lane_third;
    logic [31:0]                                 seed;
    logic                                        red_start;
    logic [31:0]                                 red_result;
    valu_pkg::lane_result_t [valu_pkg::LANES-1:0] lane_res;
    logic [valu_pkg::VLENB-1:0]                  mask_next;

    logic                                        valid_q1;
    logic                                        valid_q2;
    valu_pkg::valu_op_e                          op_q1;
    valu_pkg::valu_op_e                          op_q2;
    valu_pkg::vsew_e                             sew_q1;
    logic [valu_pkg::VLEN-1:0]                   lane_data_q;
    logic [valu_pkg::VLENB-1:0]                  mask_q;

    function automatic logic is_reduction(input valu_pkg::valu_op_e op);
        return op inside {valu_pkg::VREDSUM, valu_pkg::VREDAND, valu_pkg::VREDOR,
                          valu_pkg::VREDXOR, valu_pkg::VREDMIN, valu_pkg::VREDMAX};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Element activity, indexed by element number
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < valu_pkg::VLENB; i++) begin
            in_vl[i]  = valu_pkg::VL_W'(i) < req_i.vl;
            // Merge selects with the mask, so only vl limits it
            active[i] = in_vl[i] && ((req_i.vm && req_i.op != valu_pkg::VMERGE)
                                     || req_i.mask[i]);
        end
        for (int k = 0; k < valu_pkg::LANES; k++) begin
            case (req_i.sew)
                valu_pkg::EW8:  lane_active[k] = active[k*8 +: 8];
                valu_pkg::EW16: lane_active[k] = {4'b0, active[k*4 +: 4]};
                default:        lane_active[k] = {6'b0, active[k*2 +: 2]};
            endcase
        end
    end

    // For merge, body elements with a clear mask bit fall back to the
    // first operand; tail elements still keep the destination
    always_comb begin
        int idx;
        for (int j = 0; j < valu_pkg::VLENB; j++) begin
            case (req_i.sew)
                valu_pkg::EW8:  idx = j;
                valu_pkg::EW16: idx = j / 2;
                default:        idx = j / 4;
            endcase
            if (req_i.op == valu_pkg::VMERGE && in_vl[idx]) begin
                lane_third[j*8 +: 8] = first_operand_i[j*8 +: 8];
            end else begin
                lane_third[j*8 +: 8] = third_operand_i[j*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Lanes and reduction
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < valu_pkg::LANES; k++) begin : g_lane
        valu_lane u_lane (
            .clk      (clk),
            .reset_n  (reset_n),
            .first_i  (first_operand_i [k*valu_pkg::LLEN +: valu_pkg::LLEN]),
            .second_i (second_operand_i[k*valu_pkg::LLEN +: valu_pkg::LLEN]),
            .third_i  (lane_third      [k*valu_pkg::LLEN +: valu_pkg::LLEN]),
            .op_i     (req_i.op),
            .sew_i    (req_i.sew),
            .active_i (lane_active[k]),
            .result_o (lane_res[k])
        );
    end

    always_comb begin
        case (req_i.sew)
            valu_pkg::EW8:  seed = {24'b0, second_operand_i[7:0]};
            valu_pkg::EW16: seed = {16'b0, second_operand_i[15:0]};
            default:        seed = second_operand_i[31:0];
        endcase
    end

    assign red_start = req_valid_i && is_reduction(req_i.op);

    valu_reduction u_reduction (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (red_start),
        .op_i     (req_i.op),
        .sew_i    (req_i.sew),
        .vector_i (first_operand_i),
        .seed_i   (seed),
        .active_i (active),
        .result_o (red_result)
    );

    //////////////////////////////////////////////////////////////////////
    // Pipeline and result select
    //////////////////////////////////////////////////////////////////////

    // Lane compare bits packed by element index
    always_comb begin
        case (sew_q1)
            valu_pkg::EW8:  mask_next = {lane_res[1].cmp, lane_res[0].cmp};
            valu_pkg::EW16: mask_next = {8'b0, lane_res[1].cmp[3:0], lane_res[0].cmp[3:0]};
            default:        mask_next = {12'b0, lane_res[1].cmp[1:0], lane_res[0].cmp[1:0]};
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q1 <= 1'b0;
            valid_q2 <= 1'b0;
        end else begin
            valid_q1 <= req_valid_i;
            valid_q2 <= valid_q1;
        end
    end

    always_ff @(posedge clk) begin
        op_q1       <= req_i.op;
        sew_q1      <= req_i.sew;
        op_q2       <= op_q1;
        lane_data_q <= {lane_res[1].data, lane_res[0].data};
        mask_q      <= mask_next;
    end

    assign result_valid_o = valid_q2;
    assign result_mask_o  = mask_q;
    assign result_o       = is_reduction(op_q2) ? {96'b0, red_result} : lane_data_q;

endmodule

`default_nettype wire

// File: test/vector_alu_properties.sv
// Covers only the valid pipeline of vector_alu; data is checked by the testbench
`timescale 1ns/1ns
`default_nettype none

module vector_alu_properties (
    input logic clk,
    input logic reset_n,
    input logic req_valid_i,
    input logic result_valid_o
);

    valid_low_in_reset: assert property (@(posedge clk) !reset_n |-> !result_valid_o)
        else $error("result_valid_o high while reset is asserted");

    // First two edges after release still see the reset pipeline
    valid_low_after_reset: assert property (@(posedge clk) $rose(reset_n) |-> !result_valid_o)
        else $error("result_valid_o high in the first cycle after reset");

    valid_low_next_cycle: assert property (@(posedge clk) $rose(reset_n) |=> !result_valid_o)
        else $error("result_valid_o high in the second cycle after reset");

    valid_latency: assert property (@(posedge clk) disable iff (!reset_n)
                                    result_valid_o == $past(req_valid_i, 2))
        else $error("result_valid_o does not follow req_valid_i by 2 cycles");

endmodule

bind vector_alu vector_alu_properties u_properties (
    .clk            (clk),
    .reset_n        (reset_n),
    .req_valid_i    (req_valid_i),
    .result_valid_o (result_valid_o)
);

`default_nettype wire

// File: test/tb_vector_alu.sv
// Expects every result exactly 2 cycles after its strobe; sew 3, VNOP and vl above 16 go untested
`timescale 1ns/1ns
`default_nettype none

module tb_vector_alu;

    logic                       clk;
    logic                       reset_n;
    logic                       req_valid;
    valu_pkg::valu_req_t        req;
    logic [valu_pkg::VLEN-1:0]  first_operand;
    logic [valu_pkg::VLEN-1:0]  second_operand;
    logic [valu_pkg::VLEN-1:0]  third_operand;
    logic                       result_valid;
    logic [valu_pkg::VLEN-1:0]  result;
    logic [valu_pkg::VLENB-1:0] result_mask;

    integer       seed;
    int           cycle_count = 0;
    logic [127:0] corner_a;
    logic [127:0] corner_b;
    // Expected outputs per cycle, oldest first
    logic         exp_valid_q[$];
    logic [127:0] exp_result_q[$];
    logic [15:0]  exp_mask_q[$];

    vector_alu UUT (
        .clk              (clk),
        .reset_n          (reset_n),
        .req_valid_i      (req_valid),
        .req_i            (req),
        .first_operand_i  (first_operand),
        .second_operand_i (second_operand),
        .third_operand_i  (third_operand),
        .result_valid_o   (result_valid),
        .result_o         (result),
        .result_mask_o    (result_mask)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Tests need about 650 cycles
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= 3000) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "Timeout");
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("Something failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int pick_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [127:0] random_vector();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    function automatic valu_pkg::valu_op_e op_from_int(input int n);
        return valu_pkg::valu_op_e'(n[4:0]);
    endfunction

    function automatic valu_pkg::vsew_e sew_from_int(input int n);
        return valu_pkg::vsew_e'(n[1:0]);
    endfunction

    function automatic valu_pkg::valu_req_t build_request(input valu_pkg::valu_op_e o,
        input valu_pkg::vsew_e s, input logic unmasked,
        input logic [valu_pkg::VL_W-1:0] n, input logic [valu_pkg::VLENB-1:0] m);
        return '{op: o, sew: s, vm: unmasked, vl: n, mask: m};
    endfunction

    function automatic valu_pkg::valu_req_t mixed_request(input int first_op, input int span);
        return build_request(op_from_int(first_op + pick_below(span)),
                             sew_from_int(pick_below(3)), pick_below(2) == 1,
                             5'(pick_below(17)), 16'($random(seed)));
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] extract_element(input logic [127:0] v, input int bits,
                                                    input int i);
        logic [127:0] shifted;
        shifted = v >> (i * bits);
        return shifted[31:0] & ({32{1'b1}} >> (32 - bits));
    endfunction

    function automatic logic [127:0] insert_element(input logic [127:0] v, input int bits,
                                                    input int i, input logic [31:0] x);
        logic [127:0] field;
        field = {96'b0, {32{1'b1}} >> (32 - bits)} << (i * bits);
        return (v & ~field) | (({96'b0, x} << (i * bits)) & field);
    endfunction

    function automatic longint sign_extend(input logic [31:0] x, input int bits);
        longint v;
        v = longint'(x);
        if (x[bits-1]) begin
            v = v - (longint'(1) << bits);
        end
        return v;
    endfunction

    task automatic predict(input valu_pkg::valu_req_t r, input logic [127:0] a,
                           input logic [127:0] b, input logic [127:0] c,
                           output logic [127:0] res, output logic [15:0] msk);
        int          bits;
        logic [31:0] ea;
        logic [31:0] eb;
        logic [31:0] val;
        longint      sa;
        longint      sb;
        longint      acc;
        logic        in_vl;
        logic        act;
        bits = (r.sew == valu_pkg::EW8) ? 8 : (r.sew == valu_pkg::EW16) ? 16 : 32;
        res  = c;
        msk  = '0;
        // Seed is element 0 of the second operand
        acc  = sign_extend(extract_element(b, bits, 0), bits);
        if (r.op >= valu_pkg::VREDSUM) begin
            res = '0;
        end
        for (int i = 0; i < 128 / bits; i++) begin
            ea    = extract_element(a, bits, i);
            eb    = extract_element(b, bits, i);
            sa    = sign_extend(ea, bits);
            sb    = sign_extend(eb, bits);
            in_vl = i < int'(r.vl);
            act   = in_vl && (r.vm || r.mask[i]);
            val   = extract_element(c, bits, i);
            case (r.op)
                valu_pkg::VADD:    val = ea + eb;
                valu_pkg::VSUB:    val = ea - eb;
                valu_pkg::VAND:    val = ea & eb;
                valu_pkg::VOR:     val = ea | eb;
                valu_pkg::VXOR:    val = ea ^ eb;
                valu_pkg::VMIN:    val = (sa < sb) ? ea : eb;
                valu_pkg::VMINU:   val = (ea < eb) ? ea : eb;
                valu_pkg::VMAX:    val = (sa > sb) ? ea : eb;
                valu_pkg::VMAXU:   val = (ea > eb) ? ea : eb;
                valu_pkg::VMERGE:  val = r.mask[i] ? eb : ea;
                valu_pkg::VMSEQ:   msk[i] = act && (ea == eb);
                valu_pkg::VMSLT:   msk[i] = act && (sa < sb);
                valu_pkg::VMSLTU:  msk[i] = act && (ea < eb);
                valu_pkg::VREDSUM: acc = act ? acc + sa : acc;
                valu_pkg::VREDAND: acc = act ? acc & sa : acc;
                valu_pkg::VREDOR:  acc = act ? acc | sa : acc;
                valu_pkg::VREDXOR: acc = act ? acc ^ sa : acc;
                valu_pkg::VREDMIN: acc = (act && sa < acc) ? sa : acc;
                valu_pkg::VREDMAX: acc = (act && sa > acc) ? sa : acc;
                default: ;
            endcase
            if (r.op == valu_pkg::VMERGE ? in_vl : (act && r.op < valu_pkg::VREDSUM)) begin
                res = insert_element(res, bits, i, val);
            end
        end
        if (r.op >= valu_pkg::VREDSUM) begin
            res = insert_element(res, bits, 0, 32'(acc));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////////////////////////

    // One cycle: check what is due now, then drive the next request
    task automatic issue(input logic valid, input valu_pkg::valu_req_t r, input logic [127:0] a,
                         input logic [127:0] b, input logic [127:0] c);
        logic         exp_valid;
        logic [127:0] exp_result;
        logic [15:0]  exp_mask;
        @(negedge clk);
        exp_valid  = exp_valid_q.pop_front();
        exp_result = exp_result_q.pop_front();
        exp_mask   = exp_mask_q.pop_front();
        check_value("result_valid_o", 128'(result_valid), 128'(exp_valid));
        if (exp_valid) begin
            check_value("result_o", result, exp_result);
            check_value("result_mask_o", 128'(result_mask), 128'(exp_mask));
        end
        req_valid      = valid;
        req            = r;
        first_operand  = a;
        second_operand = b;
        third_operand  = c;
        predict(r, a, b, c, exp_result, exp_mask);
        exp_valid_q.push_back(valid);
        exp_result_q.push_back(exp_result);
        exp_mask_q.push_back(exp_mask);
    endtask

    task automatic idle(input int n);
        repeat (n) issue(1'b0, '0, '0, '0, '0);
    endtask

    task automatic elementwise_ops();
        for (int s = 0; s < 3; s++) begin
            for (int o = int'(valu_pkg::VADD); o <= int'(valu_pkg::VMAXU); o++) begin
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      corner_a, corner_b, random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      corner_b, corner_a, random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      random_vector(), random_vector(), random_vector());
            end
        end
        idle(2);
    endtask

    task automatic masking_and_tail();
        for (int s = 0; s < 3; s++) begin
            issue(1'b1, build_request(valu_pkg::VADD, sew_from_int(s), 1'b1, 5'd3, 16'h0),
                  corner_a, corner_b, random_vector());
            issue(1'b1, build_request(valu_pkg::VXOR, sew_from_int(s), 1'b1, 5'd0, 16'hffff),
                  corner_a, corner_b, random_vector());
            issue(1'b1, build_request(valu_pkg::VMAX, sew_from_int(s), 1'b0, 5'd16, 16'ha5c3),
                  corner_a, corner_b, random_vector());
            issue(1'b1, build_request(valu_pkg::VSUB, sew_from_int(s), 1'b0, 5'd7, 16'h3c5a),
                  random_vector(), random_vector(), random_vector());
            issue(1'b1, build_request(valu_pkg::VMERGE, sew_from_int(s), 1'b0, 5'd16, 16'h9a6c),
                  random_vector(), random_vector(), random_vector());
            // Merge ignores vm
            issue(1'b1, build_request(valu_pkg::VMERGE, sew_from_int(s), 1'b1, 5'd3, 16'h0f35),
                  random_vector(), random_vector(), random_vector());
        end
        idle(2);
    endtask

    task automatic compare_ops();
        logic [127:0] near_a;
        near_a = corner_a ^ 128'h00000000_0000ff00_00000000_00010000;
        for (int s = 0; s < 3; s++) begin
            for (int o = int'(valu_pkg::VMSEQ); o <= int'(valu_pkg::VMSLTU); o++) begin
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      corner_a, near_a, random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      corner_b, corner_a, random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b0, 5'd5, 16'h6b9d),
                      corner_a, near_a, random_vector());
            end
        end
        idle(2);
    endtask

    task automatic reduction_ops();
        for (int s = 0; s < 3; s++) begin
            for (int o = int'(valu_pkg::VREDSUM); o <= int'(valu_pkg::VREDMAX); o++) begin
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd16, 16'h0),
                      corner_a, random_vector(), random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b0, 5'd5, 16'h0f3a),
                      random_vector(), random_vector(), random_vector());
                // No active element leaves only the seed
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b1, 5'd0, 16'hffff),
                      random_vector(), corner_b, random_vector());
                issue(1'b1, build_request(op_from_int(o), sew_from_int(s), 1'b0, 5'd16, 16'h0),
                      random_vector(), corner_a, random_vector());
            end
        end
        idle(2);
    endtask

    // Reductions and element-wise ops alternate with no gaps
    task automatic back_to_back();
        for (int i = 0; i < 24; i++) begin
            if (i % 2 == 0) begin
                issue(1'b1, mixed_request(int'(valu_pkg::VREDSUM), 6),
                      random_vector(), random_vector(), random_vector());
            end else begin
                issue(1'b1, mixed_request(int'(valu_pkg::VADD), 13),
                      random_vector(), random_vector(), random_vector());
            end
        end
        idle(2);
    endtask

    task automatic random_traffic();
        for (int n = 0; n < 300; n++) begin
            if (pick_below(8) == 0) begin
                idle(1);
            end
            issue(1'b1, mixed_request(int'(valu_pkg::VADD), 19),
                  random_vector(), random_vector(), random_vector());
        end
        idle(2);
    endtask

    initial begin
        seed           = 97;
        corner_a       = 128'h7fffffff_80000000_ff807f01_0180fe7f;
        corner_b       = 128'h00000001_ffffffff_7f80ff01_fe7f8001;
        reset_n        = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        first_operand  = '0;
        second_operand = '0;
        third_operand  = '0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        check_value("result_valid_o", 128'(result_valid), 128'h0);
        // Two idle cycles already in the pipeline
        repeat (2) begin
            exp_valid_q.push_back(1'b0);
            exp_result_q.push_back('0);
            exp_mask_q.push_back('0);
        end
        elementwise_ops();
        masking_and_tail();
        compare_ops();
        reduction_ops();
        back_to_back();
        random_traffic();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hw/valu_pkg.sv
hw/valu_lane.sv
hw/valu_reduction.sv
hw/vector_alu.sv
test/vector_alu_properties.sv
test/tb_vector_alu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vector ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_vector_alu \
    -o sim_vector_alu
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/sim_vector_alu > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
fi

if grep -qx "Everything OK" sim.log; then
    if [ $run_status -eq 0 ]; then
        echo "Simulation passed"
        exit 0
    fi
fi

echo "Simulation did not pass, see sim.log"
exit 1
